// File: list.f
logic/msr_pkg.sv
logic/msr_exec_unit.sv
logic/msr_psr_file.sv
logic/msr_tlb_bank.sv
logic/msr_subsystem_top.sv
verif/msr_sva.sv
verif/msr_tb.sv

// File: Makefile
# Verilator flow for the MSR subsystem testbench

VERILATOR ?= verilator
TOP       ?= msr_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
ERR_LIMIT ?= 100
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/msr_tb.sv
//////////////////////////////
// Self-checking testbench of the MSR subsystem.
// Expected values come from a shadow model of all registers.
// Stimulus keeps the one-hot rules of a commit.
//////////////////////////////
`timescale 1ns/1ps

module msr_tb
   import msr_pkg::*;
();

   // Five times the expected test length
   localparam int test_cycles = 600;
   localparam int max_cycles  = 5 * test_cycles;

   // Event kinds of commit_event
   localparam int ev_syscall = 0;
   localparam int ev_ext     = 1;
   localparam int ev_mmu     = 2;
   localparam int ev_ret     = 3;
   localparam int ev_cc      = 4;
   localparam int ev_lsa     = 5;

   logic            clk = 1'b0;
   logic            arst_n;
   logic            rmsr;
   logic            wmsr;
   msr_word_t       operand_1;
   msr_word_t       operand_2;
   msr_word_t       operand_3;
   logic            commit;
   logic            cc_we;
   logic            cc_nxt;
   logic            ret;
   logic            syscall;
   logic            ext_exp;
   logic            mmu_exp;
   logic            let_lsa_pc;
   logic [pc_w-1:0] insn_pc;
   msr_word_t       linkaddr;
   logic            dout_valid;
   msr_word_t       dout;
   psr_t            psr;
   logic            exp_ent;

   // Shadow model
   psr_t      sh_psr;
   psr_t      sh_epsr;
   msr_word_t sh_epc;
   msr_word_t sh_elsa;
   msr_word_t sh_imm_l [tlb_depth];
   msr_word_t sh_imm_h [tlb_depth];
   msr_word_t sh_dmm_l [tlb_depth];
   msr_word_t sh_dmm_h [tlb_depth];

   int seed   = 25646;
   int cycles = 0;
   int checks = 0;
   int errors = 0;
   int test_checks;
   int test_errors;

   always #50 clk = ~clk;

   msr_subsystem_top uut (
      .clk        (clk),
      .arst_n     (arst_n),
      .rmsr       (rmsr),
      .wmsr       (wmsr),
      .operand_1  (operand_1),
      .operand_2  (operand_2),
      .operand_3  (operand_3),
      .commit     (commit),
      .cc_we      (cc_we),
      .cc_nxt     (cc_nxt),
      .ret        (ret),
      .syscall    (syscall),
      .ext_exp    (ext_exp),
      .mmu_exp    (mmu_exp),
      .let_lsa_pc (let_lsa_pc),
      .insn_pc    (insn_pc),
      .linkaddr   (linkaddr),
      .dout_valid (dout_valid),
      .dout       (dout),
      .psr        (psr),
      .exp_ent    (exp_ent)
   );

   // Assertions on the execute unit's controls
   bind msr_subsystem_top msr_sva sva_chk (
      .clk          (clk),
      .arst_n       (arst_n),
      .commit       (commit),
      .ret          (ret),
      .cc_we        (cc_we),
      .syscall      (syscall),
      .ext_exp      (ext_exp),
      .mmu_exp      (mmu_exp),
      .let_lsa_pc   (let_lsa_pc),
      .wmsr_psr_we  (exec_unit.wmsr_psr_we),
      .wmsr_elsa_we (exec_unit.wmsr_elsa_we),
      .psr_field_we (psr_field_we),
      .epsr_we      (epsr_we),
      .epc_we       (epc_we),
      .elsa_we      (elsa_we),
      .exp_ent      (exp_ent),
      .imm_tlbl_we  (imm_tlbl_we),
      .imm_tlbh_we  (imm_tlbh_we),
      .dmm_tlbl_we  (dmm_tlbl_we),
      .dmm_tlbh_we  (dmm_tlbh_we)
   );

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= max_cycles) begin
         $display("Timeout: tests did not finish within %0d cycles", max_cycles);
         $display("Verification failed");
         $finish;
      end
   end

   task automatic check_word(string name, msr_word_t exp, msr_word_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERROR %s: expected %h, actual %h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic check_psr(string name, psr_t exp, psr_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERROR %s: expected %h, actual %h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERROR %s: expected %h, actual %h at %0t", name, exp, act, $time);
      end
   endtask

   // Expected read data from the shadow model
   function automatic msr_word_t ref_read(msr_word_t addr);
      logic [4:0] bank;
      logic [8:0] off;
      tlb_idx_t   idx;
      msr_word_t  r;
      bank = addr[13:9];
      off  = addr[8:0];
      idx  = off[3:0];
      r    = '0;
      if (bank == 5'd0) begin
         if (off[off_psr])
            r = r | {22'd0, sh_psr};
         if (off[off_cpuid])
            r = r | cpuid_val;
         if (off[off_epsr])
            r = r | {22'd0, sh_epsr};
         if (off[off_epc])
            r = r | sh_epc;
         if (off[off_elsa])
            r = r | sh_elsa;
         if (off[off_coreid])
            r = r | coreid_val;
      end else if (bank == 5'd2 || bank == 5'd3) begin
         if (!off[8])
            r = (bank == 5'd2) ? immid_val : dmmid_val;
         else if (bank == 5'd2)
            r = off[7] ? sh_imm_h[idx] : sh_imm_l[idx];
         else
            r = off[7] ? sh_dmm_h[idx] : sh_dmm_l[idx];
      end
      return r;
   endfunction

   task automatic reset_shadow();
      // Supervisor mode only
      sh_psr    = '0;
      sh_psr.rm = 1'b1;
      sh_epsr   = '0;
      sh_epc    = '0;
      sh_elsa   = '0;
      for (int i = 0; i < tlb_depth; i++) begin
         sh_imm_l[i] = '0;
         sh_imm_h[i] = '0;
         sh_dmm_l[i] = '0;
         sh_dmm_h[i] = '0;
      end
   endtask

   // Writeback rules applied to the shadow at a committed edge
   task automatic update_shadow();
      msr_word_t addr;
      logic      ps_wr;
      tlb_idx_t  idx;
      addr  = operand_1 + operand_2;
      ps_wr = wmsr && addr[13:9] == 5'd0;
      idx   = addr[3:0];
      if (syscall || ext_exp || mmu_exp) begin
         sh_epsr     = sh_psr;
         sh_psr.rm   = 1'b1;
         sh_psr.ire  = 1'b0;
         sh_psr.imme = 1'b0;
         sh_psr.dmme = 1'b0;
      end else begin
         if (cc_we)
            sh_psr.cc = cc_nxt;
         if (ret)
            sh_psr = sh_epsr;
         if (ps_wr && addr[off_psr])
            sh_psr = operand_3[9:0];
         if (ps_wr && addr[off_epsr])
            sh_epsr = operand_3[9:0];
      end
      if (ps_wr && addr[off_epc])
         sh_epc = operand_3;
      else if (ext_exp)
         sh_epc = {insn_pc, 2'b00};
      else if (syscall)
         sh_epc = linkaddr;
      if (let_lsa_pc)
         sh_elsa = {insn_pc, 2'b00};
      else if (ps_wr && addr[off_elsa])
         sh_elsa = operand_3;
      if (wmsr && addr[8] && addr[13:9] == 5'd2) begin
         if (addr[7])
            sh_imm_h[idx] = operand_3;
         else
            sh_imm_l[idx] = operand_3;
      end
      if (wmsr && addr[8] && addr[13:9] == 5'd3) begin
         if (addr[7])
            sh_dmm_h[idx] = operand_3;
         else
            sh_dmm_l[idx] = operand_3;
      end
   endtask

   always @(posedge clk) begin
      if (arst_n && commit)
         update_shadow();
   end

   // Outputs are stable at the falling edge
   always @(negedge clk) begin
      if (arst_n) begin
         check_bit("dout_valid", rmsr, dout_valid);
         check_bit("exp_ent", commit && (syscall || ext_exp || mmu_exp), exp_ent);
         check_psr("psr", sh_psr, psr);
         if (rmsr)
            check_word("dout", ref_read(operand_1 + operand_2), dout);
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   task automatic clear_inputs();
      rmsr       = 1'b0;
      wmsr       = 1'b0;
      operand_1  = '0;
      operand_2  = '0;
      operand_3  = '0;
      commit     = 1'b0;
      cc_we      = 1'b0;
      cc_nxt     = 1'b0;
      ret        = 1'b0;
      syscall    = 1'b0;
      ext_exp    = 1'b0;
      mmu_exp    = 1'b0;
      let_lsa_pc = 1'b0;
      insn_pc    = '0;
      linkaddr   = '0;
   endtask

   // Random bits above the bank field must not matter
   function automatic msr_word_t make_addr(logic [4:0] bank, logic [8:0] off);
      msr_word_t r;
      r = $random(seed);
      return {r[31:14], bank, off};
   endfunction

   task automatic set_addr(msr_word_t addr);
      operand_1 = $random(seed);
      operand_2 = addr - operand_1;
   endtask

   task automatic read_msr(msr_word_t addr);
      next_cycle();
      clear_inputs();
      rmsr = 1'b1;
      set_addr(addr);
   endtask

   task automatic write_msr(msr_word_t addr, msr_word_t data, logic do_commit);
      next_cycle();
      clear_inputs();
      wmsr      = 1'b1;
      commit    = do_commit;
      operand_3 = data;
      set_addr(addr);
   endtask

   task automatic commit_event(int kind);
      msr_word_t r;
      next_cycle();
      clear_inputs();
      r        = $random(seed);
      insn_pc  = r[31:2];
      linkaddr = $random(seed);
      cc_nxt   = ~sh_psr.cc;
      commit   = 1'b1;
      case (kind)
         ev_syscall: syscall = 1'b1;
         ev_ext:     ext_exp = 1'b1;
         ev_mmu:     mmu_exp = 1'b1;
         ev_ret:     ret = 1'b1;
         ev_cc:      cc_we = 1'b1;
         ev_lsa:     let_lsa_pc = 1'b1;
         default:    commit = 1'b0;
      endcase
   endtask

   task automatic start_test();
      test_checks = checks;
      test_errors = errors;
   endtask

   task automatic report_test(int num, string name);
      next_cycle();
      clear_inputs();
      $display("test %0d %s: %0d checks, %0d errors", num, name,
               checks - test_checks, errors - test_errors);
   endtask

   initial begin
      msr_word_t  a;
      msr_word_t  r;
      logic [4:0] bank;
      logic [8:0] off;
      int         bit_pos;
      int         sva_fails;

      clear_inputs();
      reset_shadow();
      arst_n = 1'b0;
      repeat (8) @(posedge clk);
      #5;
      arst_n = 1'b1;

      start_test();
      read_msr(make_addr(5'd0, 9'h03f));
      for (int b = 0; b < 6; b++)
         read_msr(make_addr(5'd0, 9'd1 << b));
      read_msr(make_addr(5'd2, 9'h000));
      read_msr(make_addr(5'd3, 9'h000));
      read_msr(make_addr(5'd2, 9'h185));
      read_msr(make_addr(5'd3, 9'h10a));
      // Unmapped banks only
      for (int b = 1; b < 32; b += 3) begin
         r = $random(seed);
         read_msr(make_addr(b[4:0], r[8:0]));
      end
      report_test(1, "reset values");

      start_test();
      for (int i = 0; i < 24; i++) begin
         case (i % 4)
            0:       bit_pos = off_psr;
            1:       bit_pos = off_epsr;
            2:       bit_pos = off_epc;
            default: bit_pos = off_elsa;
         endcase
         a = make_addr(5'd0, 9'd1 << bit_pos);
         write_msr(a, $random(seed), i >= 4);
         read_msr(a);
      end
      report_test(2, "wmsr to PS bank");

      start_test();
      for (int i = 0; i < 64; i++) begin
         r    = $random(seed);
         bank = r[0] ? 5'd3 : 5'd2;
         off  = {1'b1, r[1], r[8:6], r[5:2]};
         write_msr(make_addr(bank, off), $random(seed), i % 4 != 3);
         read_msr(make_addr(bank, off));
         // Same slot in the other MMU
         read_msr(make_addr(bank ^ 5'd1, off));
      end
      report_test(3, "TLB writes");

      start_test();
      for (int i = 0; i < 6; i++) begin
         // Enables set so that the entry visibly clears them
         r = $random(seed);
         write_msr(make_addr(5'd0, 9'd1 << off_psr), r | 32'h0000_00e0, 1'b1);
         commit_event(i % 3);
         read_msr(make_addr(5'd0, 9'd1 << off_epsr));
         read_msr(make_addr(5'd0, 9'd1 << off_epc));
      end
      report_test(4, "exception entry");

      start_test();
      for (int i = 0; i < 6; i++) begin
         write_msr(make_addr(5'd0, 9'd1 << off_epsr), $random(seed), 1'b1);
         commit_event(ev_ret);
         read_msr(make_addr(5'd0, 9'd1 << off_psr));
         commit_event(ev_cc);
         read_msr(make_addr(5'd0, 9'd1 << off_psr));
      end
      report_test(5, "ret and cc update");

      start_test();
      for (int i = 0; i < 6; i++) begin
         commit_event(ev_lsa);
         read_msr(make_addr(5'd0, 9'd1 << off_elsa));
      end
      report_test(6, "ELSA capture");

      sva_fails = uut.sva_chk.fail_cnt;
      errors    = errors + sva_fails;
      $display("Summary: %0d checks, %0d errors, %0d assertion failures",
               checks, errors, sva_fails);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: verif/msr_sva.sv
//////////////////////////////
// Checks on the MSR execute unit's control outputs.
// Bound into the subsystem top, where the unit's ports and clk are visible.
// Held off during reset.
//////////////////////////////
`timescale 1ns/1ps

module msr_sva
   import msr_pkg::*;
(
   input logic                clk,
   input logic                arst_n,
   input logic                commit,
   input logic                ret,
   input logic                cc_we,
   input logic                syscall,
   input logic                ext_exp,
   input logic                mmu_exp,
   input logic                let_lsa_pc,
   input logic                wmsr_psr_we,
   input logic                wmsr_elsa_we,
   input logic [psr_nfld-1:0] psr_field_we,
   input logic                epsr_we,
   input logic                epc_we,
   input logic                elsa_we,
   input logic                exp_ent,
   input logic                imm_tlbl_we,
   input logic                imm_tlbh_we,
   input logic                dmm_tlbl_we,
   input logic                dmm_tlbh_we
);

   // Failure count, collected at the end of the run
   int unsigned fail_cnt = 0;

   logic any_we;

   assign any_we = (|psr_field_we) | epsr_we | epc_we | elsa_we | exp_ent |
                   imm_tlbl_we | imm_tlbh_we | dmm_tlbl_we | dmm_tlbh_we;

   psr_ctl_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      commit |-> $onehot0({ret, cc_we, wmsr_psr_we, syscall, ext_exp, mmu_exp}))
   else begin
      fail_cnt++;
      $error("PSR writeback controls not exclusive under commit");
   end

   elsa_ctl_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      commit |-> !(let_lsa_pc && wmsr_elsa_we))
   else begin
      fail_cnt++;
      $error("ELSA controls not exclusive under commit");
   end

   we_needs_commit: assert property (@(posedge clk) disable iff (!arst_n)
      !commit |-> !any_we)
   else begin
      fail_cnt++;
      $error("Write enable high without commit");
   end

endmodule

// File: logic/msr_subsystem_top.sv
//////////////////////////////
// MSR subsystem top level.
// commit is a single-cycle strobe; no stalls.
// Writes show on dout and psr one cycle later.
//////////////////////////////
`timescale 1ns/1ps

module msr_subsystem_top
   import msr_pkg::*;
(
   input  logic            clk,
   input  logic            arst_n,
   input  logic            rmsr,
   input  logic            wmsr,
   input  msr_word_t       operand_1,
   input  msr_word_t       operand_2,
   input  msr_word_t       operand_3,
   input  logic            commit,
   input  logic            cc_we,
   input  logic            cc_nxt,
   input  logic            ret,
   input  logic            syscall,
   input  logic            ext_exp,
   input  logic            mmu_exp,
   input  logic            let_lsa_pc,
   input  logic [pc_w-1:0] insn_pc,
   input  msr_word_t       linkaddr,
   output logic            dout_valid,
   output msr_word_t       dout,
   output psr_t            psr,
   output logic            exp_ent
);

   psr_t                psr_nxt;
   logic [psr_nfld-1:0] psr_field_we;
   psr_t                epsr;
   psr_t                epsr_nxt;
   logic                epsr_we;
   msr_word_t           epc;
   msr_word_t           epc_nxt;
   logic                epc_we;
   msr_word_t           elsa;
   msr_word_t           elsa_nxt;
   logic                elsa_we;
   tlb_idx_t            tlb_idx;
   msr_word_t           tlb_wdata;
   logic                imm_tlbl_we;
   logic                imm_tlbh_we;
   logic                dmm_tlbl_we;
   logic                dmm_tlbh_we;
   msr_word_t           imm_tlbl;
   msr_word_t           imm_tlbh;
   msr_word_t           dmm_tlbl;
   msr_word_t           dmm_tlbh;

   msr_exec_unit exec_unit (
      .rmsr         (rmsr),
      .wmsr         (wmsr),
      .operand_1    (operand_1),
      .operand_2    (operand_2),
      .operand_3    (operand_3),
      .commit       (commit),
      .cc_we        (cc_we),
      .cc_nxt       (cc_nxt),
      .ret          (ret),
      .syscall      (syscall),
      .ext_exp      (ext_exp),
      .mmu_exp      (mmu_exp),
      .let_lsa_pc   (let_lsa_pc),
      .insn_pc      (insn_pc),
      .linkaddr     (linkaddr),
      .psr          (psr),
      .epsr         (epsr),
      .epc          (epc),
      .elsa         (elsa),
      .imm_tlbl     (imm_tlbl),
      .imm_tlbh     (imm_tlbh),
      .dmm_tlbl     (dmm_tlbl),
      .dmm_tlbh     (dmm_tlbh),
      .dout_valid   (dout_valid),
      .dout         (dout),
      .psr_nxt      (psr_nxt),
      .psr_field_we (psr_field_we),
      .epsr_nxt     (epsr_nxt),
      .epsr_we      (epsr_we),
      .epc_nxt      (epc_nxt),
      .epc_we       (epc_we),
      .elsa_nxt     (elsa_nxt),
      .elsa_we      (elsa_we),
      .exp_ent      (exp_ent),
      .tlb_idx      (tlb_idx),
      .imm_tlbl_we  (imm_tlbl_we),
      .imm_tlbh_we  (imm_tlbh_we),
      .dmm_tlbl_we  (dmm_tlbl_we),
      .dmm_tlbh_we  (dmm_tlbh_we),
      .tlb_wdata    (tlb_wdata)
   );

   msr_psr_file psr_file (
      .clk          (clk),
      .arst_n       (arst_n),
      .psr_nxt      (psr_nxt),
      .psr_field_we (psr_field_we),
      .epsr_nxt     (epsr_nxt),
      .epsr_we      (epsr_we),
      .epc_nxt      (epc_nxt),
      .epc_we       (epc_we),
      .elsa_nxt     (elsa_nxt),
      .elsa_we      (elsa_we),
      .exp_ent      (exp_ent),
      .psr          (psr),
      .epsr         (epsr),
      .epc          (epc),
      .elsa         (elsa)
   );

   // Instruction MMU
   msr_tlb_bank imm_bank (
      .clk     (clk),
      .arst_n  (arst_n),
      .idx     (tlb_idx),
      .tlbl_we (imm_tlbl_we),
      .tlbh_we (imm_tlbh_we),
      .wdata   (tlb_wdata),
      .tlbl    (imm_tlbl),
      .tlbh    (imm_tlbh)
   );

   // Data MMU
   msr_tlb_bank dmm_bank (
      .clk     (clk),
      .arst_n  (arst_n),
      .idx     (tlb_idx),
      .tlbl_we (dmm_tlbl_we),
      .tlbh_we (dmm_tlbh_we),
      .wdata   (tlb_wdata),
      .tlbl    (dmm_tlbl),
      .tlbh    (dmm_tlbh)
   );

endmodule

// File: logic/msr_tlb_bank.sv
//////////////////////////////
// TLB low and high words of one MMU.
// Reads are asynchronous at idx.
// Only the MSR path is modelled, no lookup.
//////////////////////////////
`timescale 1ns/1ps

module msr_tlb_bank
   import msr_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  tlb_idx_t  idx,
   input  logic      tlbl_we,
   input  logic      tlbh_we,
   input  msr_word_t wdata,
   output msr_word_t tlbl,
   output msr_word_t tlbh
);

   msr_word_t tlbl_mem [tlb_depth];
   msr_word_t tlbh_mem [tlb_depth];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < tlb_depth; i++) begin
            tlbl_mem[i] <= '0;
            tlbh_mem[i] <= '0;
         end
      end else begin
         if (tlbl_we) begin
            tlbl_mem[idx] <= wdata;
         end
         if (tlbh_we) begin
            tlbh_mem[idx] <= wdata;
         end
      end
   end

   assign tlbl = tlbl_mem[idx];
   assign tlbh = tlbh_mem[idx];

endmodule

// File: logic/msr_psr_file.sv
//////////////////////////////
// PSR, EPSR, EPC and ELSA registers.
// exp_ent must already be gated by commit.
// Exception entry wins over any PSR or EPSR write.
// Reserved PSR bits follow the rm enable.
//////////////////////////////
`timescale 1ns/1ps

module msr_psr_file
   import msr_pkg::*;
(
   input  logic                clk,
   input  logic                arst_n,
   input  psr_t                psr_nxt,
   input  logic [psr_nfld-1:0] psr_field_we,
   input  psr_t                epsr_nxt,
   input  logic                epsr_we,
   input  msr_word_t           epc_nxt,
   input  logic                epc_we,
   input  msr_word_t           elsa_nxt,
   input  logic                elsa_we,
   input  logic                exp_ent,
   output psr_t                psr,
   output psr_t                epsr,
   output msr_word_t           epc,
   output msr_word_t           elsa
);

   // PSR
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         psr <= psr_reset_val;
      end else if (exp_ent) begin
         // Enter supervisor with interrupts and both MMUs off
         psr.rm   <= 1'b1;
         psr.ire  <= 1'b0;
         psr.imme <= 1'b0;
         psr.dmme <= 1'b0;
      end else begin
         if (psr_field_we[psr_f_cc]) begin
            psr.cc <= psr_nxt.cc;
         end
         if (psr_field_we[psr_f_rm]) begin
            psr.rm     <= psr_nxt.rm;
            psr.res_lo <= psr_nxt.res_lo;
            psr.res_hi <= psr_nxt.res_hi;
         end
         if (psr_field_we[psr_f_ire]) begin
            psr.ire <= psr_nxt.ire;
         end
         if (psr_field_we[psr_f_imme]) begin
            psr.imme <= psr_nxt.imme;
         end
         if (psr_field_we[psr_f_dmme]) begin
            psr.dmme <= psr_nxt.dmme;
         end
      end
   end

   // EPSR keeps the PSR as it was before the entry
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         epsr <= '0;
      end else if (exp_ent) begin
         epsr <= psr;
      end else if (epsr_we) begin
         epsr <= epsr_nxt;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         epc  <= '0;
         elsa <= '0;
      end else begin
         if (epc_we) begin
            epc <= epc_nxt;
         end
         if (elsa_we) begin
            elsa <= elsa_nxt;
         end
      end
   end

endmodule

// File: logic/msr_exec_unit.sv
//////////////////////////////
// MSR execute unit. Reads are purely combinational.
// All enables are gated by commit; callers keep the
// PSR and ELSA sources one-hot within a commit.
// Cache, debug, IRQ and timer banks read as zero.
//////////////////////////////
`timescale 1ns/1ps

module msr_exec_unit
   import msr_pkg::*;
(
   input  logic                rmsr,
   input  logic                wmsr,
   input  msr_word_t           operand_1,
   input  msr_word_t           operand_2,
   input  msr_word_t           operand_3,
   input  logic                commit,
   input  logic                cc_we,
   input  logic                cc_nxt,
   input  logic                ret,
   input  logic                syscall,
   input  logic                ext_exp,
   input  logic                mmu_exp,
   input  logic                let_lsa_pc,
   input  logic [pc_w-1:0]     insn_pc,
   input  msr_word_t           linkaddr,
   input  psr_t                psr,
   input  psr_t                epsr,
   input  msr_word_t           epc,
   input  msr_word_t           elsa,
   input  msr_word_t           imm_tlbl,
   input  msr_word_t           imm_tlbh,
   input  msr_word_t           dmm_tlbl,
   input  msr_word_t           dmm_tlbh,
   output logic                dout_valid,
   output msr_word_t           dout,
   output psr_t                psr_nxt,
   output logic [psr_nfld-1:0] psr_field_we,
   output psr_t                epsr_nxt,
   output logic                epsr_we,
   output msr_word_t           epc_nxt,
   output logic                epc_we,
   output msr_word_t           elsa_nxt,
   output logic                elsa_we,
   output logic                exp_ent,
   output tlb_idx_t            tlb_idx,
   output logic                imm_tlbl_we,
   output logic                imm_tlbh_we,
   output logic                dmm_tlbl_we,
   output logic                dmm_tlbh_we,
   output msr_word_t           tlb_wdata
);

   msr_word_t               msr_addr;
   logic [bank_aw-1:0]      bank;
   logic [bank_off_aw-1:0]  off;
   logic                    sel_ps;
   logic                    sel_imm;
   logic                    sel_dmm;
   logic                    tlbl_sel;
   logic                    tlbh_sel;
   msr_word_t               dout_ps;
   msr_word_t               dout_imm;
   msr_word_t               dout_dmm;
   logic                    wmsr_psr_we;
   logic                    wmsr_epsr_we;
   logic                    wmsr_epc_we;
   logic                    wmsr_elsa_we;
   psr_t                    wmsr_psr;
   msr_word_t               pc_byte;

   assign msr_addr = operand_1 + operand_2;
   assign bank     = msr_addr[bank_aw+bank_off_aw-1:bank_off_aw];
   assign off      = msr_addr[bank_off_aw-1:0];

   assign sel_ps   = (bank == bank_ps);
   assign sel_imm  = (bank == bank_imm);
   assign sel_dmm  = (bank == bank_dmm);

   // Both MMU banks share one offset layout
   assign tlbl_sel = off[off_tlbsel] & ~off[off_tlbh_sel];
   assign tlbh_sel = off[off_tlbsel] & off[off_tlbh_sel];
   assign tlb_idx  = off[tlb_aw-1:0];

   assign dout_valid = rmsr;

   // Several offset bits set at once give the OR of the registers
   assign dout_ps =
      ({msr_dw{off[off_psr]}}    & {{(msr_dw-psr_dw){1'b0}}, psr}) |
      ({msr_dw{off[off_cpuid]}}  & cpuid_val) |
      ({msr_dw{off[off_epsr]}}   & {{(msr_dw-psr_dw){1'b0}}, epsr}) |
      ({msr_dw{off[off_epc]}}    & epc) |
      ({msr_dw{off[off_elsa]}}   & elsa) |
      ({msr_dw{off[off_coreid]}} & coreid_val);

   assign dout_imm =
      ({msr_dw{~off[off_tlbsel]}} & immid_val) |
      ({msr_dw{tlbl_sel}}         & imm_tlbl) |
      ({msr_dw{tlbh_sel}}         & imm_tlbh);

   assign dout_dmm =
      ({msr_dw{~off[off_tlbsel]}} & dmmid_val) |
      ({msr_dw{tlbl_sel}}         & dmm_tlbl) |
      ({msr_dw{tlbh_sel}}         & dmm_tlbh);

   assign dout = ({msr_dw{sel_ps}}  & dout_ps) |
                 ({msr_dw{sel_imm}} & dout_imm) |
                 ({msr_dw{sel_dmm}} & dout_dmm);

   // Register selects of a wmsr
   assign wmsr_psr_we  = wmsr & sel_ps & off[off_psr];
   assign wmsr_epsr_we = wmsr & sel_ps & off[off_epsr];
   assign wmsr_epc_we  = wmsr & sel_ps & off[off_epc];
   assign wmsr_elsa_we = wmsr & sel_ps & off[off_elsa];

   assign wmsr_psr = operand_3[psr_dw-1:0];
   assign pc_byte  = {insn_pc, 2'b00};

   assign exp_ent = commit & (syscall | ext_exp | mmu_exp);

   // PSR source is wmsr data or EPSR (ret); the ALU flag overrides cc
   always_comb begin
      psr_nxt = wmsr_psr_we ? wmsr_psr : epsr;
      if (cc_we) begin
         psr_nxt.cc = cc_nxt;
      end
   end

   assign psr_field_we[psr_f_cc]   = commit & (ret | cc_we | wmsr_psr_we);
   assign psr_field_we[psr_f_rm]   = commit & (ret | wmsr_psr_we);
   assign psr_field_we[psr_f_ire]  = commit & (ret | wmsr_psr_we);
   assign psr_field_we[psr_f_imme] = commit & (ret | wmsr_psr_we);
   assign psr_field_we[psr_f_dmme] = commit & (ret | wmsr_psr_we);

   // Exception save of the old PSR is done inside the status file
   assign epsr_nxt = wmsr_psr;
   assign epsr_we  = commit & wmsr_epsr_we;

   // Syscall returns to the next insn, ext_exp to the faulting one
   assign epc_nxt = wmsr_epc_we ? operand_3 :
                    ext_exp     ? pc_byte   : linkaddr;
   assign epc_we  = commit & (ext_exp | syscall | wmsr_epc_we);

   assign elsa_nxt = let_lsa_pc ? pc_byte : operand_3;
   assign elsa_we  = commit & (let_lsa_pc | wmsr_elsa_we);

   assign tlb_wdata   = operand_3;
   assign imm_tlbl_we = commit & wmsr & sel_imm & tlbl_sel;
   assign imm_tlbh_we = commit & wmsr & sel_imm & tlbh_sel;
   assign dmm_tlbl_we = commit & wmsr & sel_dmm & tlbl_sel;
   assign dmm_tlbh_we = commit & wmsr & sel_dmm & tlbh_sel;

endmodule

// File: logic/msr_pkg.sv
//////////////////////////////
// Shared widths, bank map, PSR layout and constants of the MSR subsystem.
// The bank code is address bits 13:9 and the offset is bits 8:0.
// Address bits above 13 are ignored by the decoder.
// ID values are fixed constants, not straps.
//////////////////////////////
package msr_pkg;

   // Data and address widths
   localparam int msr_dw      = 32;
   localparam int psr_dw      = 10;
   localparam int pc_w        = 30;
   localparam int bank_off_aw = 9;
   localparam int bank_aw     = 5;
   localparam int tlb_aw      = 4;
   localparam int tlb_depth   = 1 << tlb_aw;

   typedef logic [msr_dw-1:0] msr_word_t;
   typedef logic [tlb_aw-1:0] tlb_idx_t;

   // Status word, MSB first
   typedef struct packed {
      logic [1:0] res_hi;
      logic       dmme;
      logic       imme;
      logic       ire;
      logic       rm;
      logic [2:0] res_lo;
      logic       cc;
   } psr_t;

   // Index of each field in the per-field write enable vector
   localparam int psr_f_cc   = 0;
   localparam int psr_f_rm   = 1;
   localparam int psr_f_ire  = 2;
   localparam int psr_f_imme = 3;
   localparam int psr_f_dmme = 4;
   localparam int psr_nfld   = 5;

   // Bank codes
   localparam logic [bank_aw-1:0] bank_ps  = 5'd0;
   localparam logic [bank_aw-1:0] bank_imm = 5'd2;
   localparam logic [bank_aw-1:0] bank_dmm = 5'd3;

   // PS bank, one offset bit per register
   localparam int off_psr    = 0;
   localparam int off_cpuid  = 1;
   localparam int off_epsr   = 2;
   localparam int off_epc    = 3;
   localparam int off_elsa   = 4;
   localparam int off_coreid = 5;

   // MMU banks
   localparam int off_tlbsel   = 8;
   localparam int off_tlbh_sel = 7;

   // Read-only identification words
   localparam msr_word_t cpuid_val  = 32'h0001_3201;
   localparam msr_word_t coreid_val = 32'h0000_0000;
   localparam msr_word_t immid_val  = 32'h0001_0010;
   localparam msr_word_t dmmid_val  = 32'h0001_0010;

   // Supervisor mode, everything else off
   localparam psr_t psr_reset_val = 10'h010;

endpackage
